// File: verilog/riscv_v_pkg.sv
/*
 * RISC-V vector execute shared definitions
 * Register widths, element width and operation encodings, data views
 */
package riscv_v_pkg;

    localparam int RISCV_V_VLEN = 128;
    localparam int RISCV_V_NUM_ELEMENTS_REG = 16;

    typedef logic [31:0] riscv_data_t;

    // One bit per byte element
    typedef logic [RISCV_V_NUM_ELEMENTS_REG-1:0] riscv_v_mask_t;

    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2
    } riscv_v_sew_t;

    typedef enum logic [4:0] {
        op_and  = 5'd0,
        op_or   = 5'd1,
        op_xor  = 5'd2,
        op_sll  = 5'd3,
        op_srl  = 5'd4,
        op_sra  = 5'd5,
        op_add  = 5'd6,
        op_sub  = 5'd7,
        op_adc  = 5'd8,
        op_seq  = 5'd9,
        op_slt  = 5'd10,
        op_min  = 5'd11,
        op_max  = 5'd12,
        op_mand = 5'd13,
        op_mor  = 5'd14,
        op_mxor = 5'd15,
        op_i2v  = 5'd16,
        op_v2i  = 5'd17
    } riscv_v_alu_op_t;

    // Same register seen at each element width
    typedef union packed {
        logic [RISCV_V_VLEN-1:0]             Bit;
        logic [RISCV_V_VLEN/8-1:0][7:0]      Byte;
        logic [RISCV_V_VLEN/16-1:0][15:0]    Half;
        logic [RISCV_V_VLEN/32-1:0][31:0]    Word;
    } riscv_v_alu_data_t;

    typedef struct packed {
        riscv_v_alu_op_t op;
        riscv_v_sew_t    sew;
        logic            is_signed;
        logic            is_negate_srca;
        logic            is_negate_result;
    } riscv_v_alu_ctrl_t;

endpackage : riscv_v_pkg

// File: verilog/riscv_v_logic_alu.sv
/*
 * Vector logic ALU
 * Bitwise and/or/xor over the register, per-element shifts at SEW
 */
`timescale 1ns/1ps

module riscv_v_logic_alu (
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    output riscv_v_pkg::riscv_v_alu_data_t result
);
    import riscv_v_pkg::*;

    logic is_sra;

    // Element arrives pre-extended, so one 32-bit shifter serves every SEW
    function automatic riscv_data_t shift_elem(riscv_data_t value, logic [4:0] amount,
                                               riscv_v_alu_op_t op);
        case (op)
            op_sll:  return value << amount;
            op_srl:  return value >> amount;
            default: return riscv_data_t'($signed(value) >>> amount);
        endcase
    endfunction

    assign is_sra = (ctrl.op == op_sra);

    always_comb begin
        result = '0;
        case (ctrl.op)
            op_and: result.Bit = srca.Bit & srcb.Bit;
            op_or:  result.Bit = srca.Bit | srcb.Bit;
            op_xor: result.Bit = srca.Bit ^ srcb.Bit;
            op_sll, op_srl, op_sra: begin
                case (ctrl.sew)
                    sew8: begin
                        for (int i = 0; i < RISCV_V_VLEN/8; i++) begin
                            result.Byte[i] = 8'(shift_elem(
                                {{24{is_sra & srca.Byte[i][7]}}, srca.Byte[i]},
                                {2'b00, srcb.Byte[i][2:0]}, ctrl.op));
                        end
                    end
                    sew16: begin
                        for (int i = 0; i < RISCV_V_VLEN/16; i++) begin
                            result.Half[i] = 16'(shift_elem(
                                {{16{is_sra & srca.Half[i][15]}}, srca.Half[i]},
                                {1'b0, srcb.Half[i][3:0]}, ctrl.op));
                        end
                    end
                    sew32: begin
                        for (int i = 0; i < RISCV_V_VLEN/32; i++) begin
                            result.Word[i] = shift_elem(srca.Word[i], srcb.Word[i][4:0],
                                                        ctrl.op);
                        end
                    end
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule : riscv_v_logic_alu

// File: verilog/riscv_v_arithmetic_alu.sv
/*
 * Vector arithmetic ALU
 * Per-element add, sub, add with carry, compares and min/max at SEW
 */
`timescale 1ns/1ps

module riscv_v_arithmetic_alu (
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    input  riscv_v_pkg::riscv_v_mask_t     carry_in,
    output riscv_v_pkg::riscv_v_alu_data_t result
);
    import riscv_v_pkg::*;

    // One extra bit so a signed compare covers both signed and unsigned
    function automatic logic [32:0] extend(riscv_data_t value, riscv_v_sew_t sew,
                                           logic is_signed);
        case (sew)
            sew8:    return {{25{is_signed & value[7]}}, value[7:0]};
            sew16:   return {{17{is_signed & value[15]}}, value[15:0]};
            default: return {is_signed & value[31], value};
        endcase
    endfunction

    // Low SEW bits of the return value hold the element result
    function automatic riscv_data_t elem_op(riscv_data_t a, riscv_data_t b, logic carry,
                                            riscv_v_alu_ctrl_t c);
        logic [32:0] ea;
        logic [32:0] eb;
        logic        less;
        ea   = extend(a, c.sew, c.is_signed);
        eb   = extend(b, c.sew, c.is_signed);
        less = $signed(ea) < $signed(eb);
        case (c.op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_adc:  return a + b + riscv_data_t'(carry);
            op_seq:  return riscv_data_t'(ea == eb);
            op_slt:  return riscv_data_t'(less);
            op_min:  return less ? a : b;
            op_max:  return less ? b : a;
            default: return '0;
        endcase
    endfunction

    always_comb begin
        result = '0;
        case (ctrl.sew)
            sew8: begin
                for (int i = 0; i < RISCV_V_VLEN/8; i++) begin
                    result.Byte[i] = 8'(elem_op(32'(srca.Byte[i]), 32'(srcb.Byte[i]),
                                                carry_in[i], ctrl));
                end
            end
            sew16: begin
                for (int i = 0; i < RISCV_V_VLEN/16; i++) begin
                    result.Half[i] = 16'(elem_op(32'(srca.Half[i]), 32'(srcb.Half[i]),
                                                 carry_in[i], ctrl));
                end
            end
            sew32: begin
                for (int i = 0; i < RISCV_V_VLEN/32; i++) begin
                    result.Word[i] = elem_op(srca.Word[i], srcb.Word[i], carry_in[i], ctrl);
                end
            end
            default: result = '0;
        endcase
    end

endmodule : riscv_v_arithmetic_alu

// File: verilog/riscv_v_mask_alu.sv
/*
 * Vector mask ALU
 * Mask and/or/xor with optional source A and result negation
 */
`timescale 1ns/1ps

module riscv_v_mask_alu (
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_v_mask_t     srca,
    input  riscv_v_pkg::riscv_v_mask_t     srcb,
    output riscv_v_pkg::riscv_v_mask_t     result
);
    import riscv_v_pkg::*;

    riscv_v_mask_t srca_eff;
    riscv_v_mask_t raw;

    assign srca_eff = ctrl.is_negate_srca ? ~srca : srca;

    always_comb begin
        case (ctrl.op)
            op_mand: raw = srca_eff & srcb;
            op_mor:  raw = srca_eff | srcb;
            op_mxor: raw = srca_eff ^ srcb;
            default: raw = '0;
        endcase
    end

    // Negation only for mask ops, zero otherwise
    assign result = (ctrl.op inside {op_mand, op_mor, op_mxor})
                  ? (ctrl.is_negate_result ? ~raw : raw) : '0;

endmodule : riscv_v_mask_alu

// File: verilog/riscv_v_permutation_alu.sv
/*
 * Vector permutation ALU
 * Scalar broadcast into every element, element 0 extraction to scalar
 */
`timescale 1ns/1ps

module riscv_v_permutation_alu (
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_data_t       integer_data_in,
    input  riscv_v_pkg::riscv_v_alu_data_t vector_data_in,
    output riscv_v_pkg::riscv_data_t       integer_data_out,
    output riscv_v_pkg::riscv_v_alu_data_t vector_data_out
);
    import riscv_v_pkg::*;

    always_comb begin
        vector_data_out = '0;
        if (ctrl.op == op_i2v) begin
            case (ctrl.sew)
                sew8:    vector_data_out.Bit = {(RISCV_V_VLEN/8){integer_data_in[7:0]}};
                sew16:   vector_data_out.Bit = {(RISCV_V_VLEN/16){integer_data_in[15:0]}};
                sew32:   vector_data_out.Bit = {(RISCV_V_VLEN/32){integer_data_in}};
                default: vector_data_out = '0;
            endcase
        end
    end

    // Element 0 sign-extended
    always_comb begin
        integer_data_out = '0;
        if (ctrl.op == op_v2i) begin
            case (ctrl.sew)
                sew8:    integer_data_out = 32'($signed(vector_data_in.Byte[0]));
                sew16:   integer_data_out = 32'($signed(vector_data_in.Half[0]));
                sew32:   integer_data_out = vector_data_in.Word[0];
                default: integer_data_out = '0;
            endcase
        end
    end

endmodule : riscv_v_permutation_alu

// File: verilog/riscv_v_exe_alu.sv
/*
 * Vector execute ALU
 * Feeds the sources to the four sub-ALUs and merges their results
 */
`timescale 1ns/1ps

module riscv_v_exe_alu (
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t srca_exe,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb_exe,
    input  riscv_v_pkg::riscv_data_t       src_int_exe,
    input  riscv_v_pkg::riscv_v_mask_t     mask_exe,
    output riscv_v_pkg::riscv_data_t       int_result_exe,
    output riscv_v_pkg::riscv_v_alu_data_t vec_result_exe,
    output riscv_v_pkg::riscv_v_mask_t     mask_result_exe
);
    import riscv_v_pkg::*;

    riscv_v_alu_data_t logic_result;
    riscv_v_alu_data_t arithmetic_result;
    riscv_v_alu_data_t permutation_result;

    // Sub-ALUs decode disjoint ops and drive zero otherwise
    assign vec_result_exe.Bit = logic_result.Bit
                              | arithmetic_result.Bit
                              | permutation_result.Bit;

    riscv_v_logic_alu logic_alu (
        .ctrl   (ctrl),
        .srca   (srca_exe),
        .srcb   (srcb_exe),
        .result (logic_result)
    );

    riscv_v_arithmetic_alu arithmetic_alu (
        .ctrl     (ctrl),
        .srca     (srca_exe),
        .srcb     (srcb_exe),
        .carry_in (mask_exe),
        .result   (arithmetic_result)
    );

    riscv_v_mask_alu mask_alu (
        .ctrl   (ctrl),
        .srca   (srca_exe.Bit[RISCV_V_NUM_ELEMENTS_REG-1:0]),
        .srcb   (srcb_exe.Bit[RISCV_V_NUM_ELEMENTS_REG-1:0]),
        .result (mask_result_exe)
    );

    riscv_v_permutation_alu permutation_alu (
        .ctrl             (ctrl),
        .integer_data_in  (src_int_exe),
        .vector_data_in   (srca_exe),
        .integer_data_out (int_result_exe),
        .vector_data_out  (permutation_result)
    );

endmodule : riscv_v_exe_alu

// File: verilog/riscv_v_exe_stage.sv
/*
 * Vector execute stage
 * Operation register, combinational ALU, then result register
 */
`timescale 1ns/1ps

module riscv_v_exe_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  riscv_v_pkg::riscv_v_alu_ctrl_t ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    input  riscv_v_pkg::riscv_data_t       src_int,
    input  riscv_v_pkg::riscv_v_mask_t     mask,
    output logic                           out_valid,
    output riscv_v_pkg::riscv_v_alu_data_t vec_result,
    output riscv_v_pkg::riscv_data_t       int_result,
    output riscv_v_pkg::riscv_v_mask_t     mask_result
);
    import riscv_v_pkg::*;

    logic              op_valid;
    riscv_v_alu_ctrl_t op_ctrl;
    riscv_v_alu_data_t op_srca;
    riscv_v_alu_data_t op_srcb;
    riscv_data_t       op_src_int;
    riscv_v_mask_t     op_mask;

    riscv_v_alu_data_t alu_vec_result;
    riscv_data_t       alu_int_result;
    riscv_v_mask_t     alu_mask_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            op_valid  <= in_valid;
            out_valid <= op_valid;
        end
    end

    // Operands
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_ctrl    <= ctrl;
            op_srca    <= srca;
            op_srcb    <= srcb;
            op_src_int <= src_int;
            op_mask    <= mask;
        end
    end

    riscv_v_exe_alu exe_alu (
        .ctrl            (op_ctrl),
        .srca_exe        (op_srca),
        .srcb_exe        (op_srcb),
        .src_int_exe     (op_src_int),
        .mask_exe        (op_mask),
        .int_result_exe  (alu_int_result),
        .vec_result_exe  (alu_vec_result),
        .mask_result_exe (alu_mask_result)
    );

    // Results held while no operation is in the stage
    always_ff @(posedge clk) begin
        if (op_valid) begin
            vec_result  <= alu_vec_result;
            int_result  <= alu_int_result;
            mask_result <= alu_mask_result;
        end
    end

endmodule : riscv_v_exe_stage

// File: test/riscv_v_exe_checker.sv
/*
 * Assertions on the execute stage valid timing and scalar result
 */
`timescale 1ns/1ps

module riscv_v_exe_checker (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           in_valid,
    input logic                           out_valid,
    input riscv_v_pkg::riscv_v_alu_ctrl_t op_ctrl,
    input riscv_v_pkg::riscv_data_t       int_result
);
    import riscv_v_pkg::*;

    int fail_count = 0;

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    // Two edges of latency while reset stayed high over both
    valid_latency: assert property (@(posedge clk)
        $past(rst_n, 1) && $past(rst_n, 2) |-> out_valid == $past(in_valid, 2))
        else begin
            $error("out_valid does not follow in_valid by two cycles");
            fail_count++;
        end

    int_zero_unless_v2i: assert property (@(posedge clk)
        out_valid && $past(op_ctrl.op) != op_v2i |-> int_result == '0)
        else begin
            $error("int_result nonzero for an operation other than v2i");
            fail_count++;
        end

endmodule : riscv_v_exe_checker

// File: test/riscv_v_exe_model.svh
/*
 * Reference model for the vector execute stage
 * Expected vector, scalar and mask results from the operation rules
 */
`ifndef RISCV_V_EXE_MODEL_SVH
`define RISCV_V_EXE_MODEL_SVH

function automatic int sew_width(riscv_v_sew_t sew);
    case (sew)
        sew8:    return 8;
        sew16:   return 16;
        default: return 32;
    endcase
endfunction

function automatic logic [31:0] elem_mask(int w);
    return (w == 32) ? 32'hffff_ffff : (32'h1 << w) - 32'h1;
endfunction

// Element as a number in two's complement when sgn is set
function automatic longint elem_value(logic [31:0] raw, int w, logic sgn);
    if (sgn && raw[w-1])
        return longint'(raw) - (longint'(1) << w);
    return longint'(raw);
endfunction

function automatic riscv_v_alu_data_t model_vec(riscv_v_alu_ctrl_t c, riscv_v_alu_data_t a,
                                                riscv_v_alu_data_t b, riscv_data_t s,
                                                riscv_v_mask_t m);
    riscv_v_alu_data_t res;
    int                w;
    int                sh;
    logic [31:0]       ea;
    logic [31:0]       eb;
    logic [31:0]       er;
    longint            va;
    longint            vb;
    w = sew_width(c.sew);
    res = '0;
    for (int i = 0; i < RISCV_V_VLEN / w; i++) begin
        ea = 32'(a.Bit >> (i * w)) & elem_mask(w);
        eb = 32'(b.Bit >> (i * w)) & elem_mask(w);
        va = elem_value(ea, w, c.is_signed);
        vb = elem_value(eb, w, c.is_signed);
        sh = int'(eb[4:0]) % w;
        case (c.op)
            op_and:  er = ea & eb;
            op_or:   er = ea | eb;
            op_xor:  er = ea ^ eb;
            op_sll:  er = ea << sh;
            op_srl:  er = ea >> sh;
            op_sra:  er = 32'(elem_value(ea, w, 1'b1) >>> sh);
            op_add:  er = ea + eb;
            op_sub:  er = ea - eb;
            op_adc:  er = ea + eb + 32'(m[i]);
            op_seq:  er = 32'(ea == eb);
            op_slt:  er = 32'(va < vb);
            op_min:  er = (va < vb) ? ea : eb;
            op_max:  er = (va < vb) ? eb : ea;
            op_i2v:  er = s;
            default: er = '0;
        endcase
        res.Bit = res.Bit | (128'(er & elem_mask(w)) << (i * w));
    end
    return res;
endfunction

// Element 0 sign-extended on v2i only
function automatic riscv_data_t model_int(riscv_v_alu_ctrl_t c, riscv_v_alu_data_t a);
    int w;
    w = sew_width(c.sew);
    if (c.op != op_v2i)
        return '0;
    return 32'(elem_value(a.Word[0] & elem_mask(w), w, 1'b1));
endfunction

function automatic riscv_v_mask_t model_mask(riscv_v_alu_ctrl_t c, riscv_v_alu_data_t a,
                                             riscv_v_alu_data_t b);
    riscv_v_mask_t ma;
    riscv_v_mask_t r;
    ma = c.is_negate_srca ? ~a.Bit[15:0] : a.Bit[15:0];
    case (c.op)
        op_mand: r = ma & b.Bit[15:0];
        op_mor:  r = ma | b.Bit[15:0];
        op_mxor: r = ma ^ b.Bit[15:0];
        default: return '0;
    endcase
    return c.is_negate_result ? ~r : r;
endfunction

`endif

// File: test/riscv_v_exe_tb.sv
/*
 * Testbench for the vector execute stage
 * Random operations checked against a model, plus latency and reset
 */
`timescale 1ns/1ps

module riscv_v_exe_tb;
    import riscv_v_pkg::*;

    `include "riscv_v_exe_model.svh"

    typedef struct packed {
        riscv_v_alu_data_t vec;
        riscv_data_t       int_r;
        riscv_v_mask_t     mask_r;
        int                due;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    riscv_v_alu_ctrl_t ctrl;
    riscv_v_alu_data_t srca;
    riscv_v_alu_data_t srcb;
    riscv_data_t       src_int;
    riscv_v_mask_t     mask;
    logic              out_valid;
    riscv_v_alu_data_t vec_result;
    riscv_data_t       int_result;
    riscv_v_mask_t     mask_result;

    integer  seed;
    int      cycle = 0;
    int      error_count = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    expect_t exp_q[$];

    riscv_v_exe_stage dut0 (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .ctrl(ctrl),
        .srca(srca), .srcb(srcb), .src_int(src_int), .mask(mask),
        .out_valid(out_valid), .vec_result(vec_result), .int_result(int_result),
        .mask_result(mask_result)
    );

    bind riscv_v_exe_stage riscv_v_exe_checker checker0 (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
        .op_ctrl(op_ctrl), .int_result(int_result)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // Results sampled mid-cycle away from the clock edge
    always @(negedge clk) begin : monitor
        expect_t e;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected result at time %0t with nothing outstanding", $time);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                if (cycle != e.due) begin
                    $display("Mismatch at %0t: result in cycle %0d, expected cycle %0d",
                             $time, cycle, e.due);
                    error_count++;
                end
                if (vec_result !== e.vec) begin
                    $display("Mismatch at %0t: vec_result %h, expected %h",
                             $time, vec_result, e.vec);
                    error_count++;
                end
                if (int_result !== e.int_r) begin
                    $display("Mismatch at %0t: int_result %h, expected %h",
                             $time, int_result, e.int_r);
                    error_count++;
                end
                if (mask_result !== e.mask_r) begin
                    $display("Mismatch at %0t: mask_result %h, expected %h",
                             $time, mask_result, e.mask_r);
                    error_count++;
                end
            end
        end
    end

    function automatic riscv_v_alu_data_t rand_vec();
        riscv_v_alu_data_t v;
        for (int k = 0; k < 4; k++)
            v.Word[k] = $random(seed);
        return v;
    endfunction

    // Elements drawn from zero, one, all ones and the signed limits
    function automatic riscv_v_alu_data_t corner_vec(riscv_v_sew_t sew);
        riscv_v_alu_data_t v;
        logic [31:0]       choice [5];
        int                w;
        w = sew_width(sew);
        choice = '{32'h0, 32'h1, 32'hffff_ffff, 32'h1 << (w - 1), (32'h1 << (w - 1)) - 1};
        v = '0;
        for (int i = 0; i < RISCV_V_VLEN / w; i++)
            v.Bit = v.Bit | (128'(choice[$unsigned($random(seed)) % 5] & elem_mask(w))
                             << (i * w));
        return v;
    endfunction

    function automatic riscv_v_alu_op_t pick_op(riscv_v_alu_op_t lo, riscv_v_alu_op_t hi);
        int span;
        span = int'(hi) - int'(lo) + 1;
        return riscv_v_alu_op_t'(5'(int'(lo) + int'($unsigned($random(seed)) % span)));
    endfunction

    function automatic riscv_v_sew_t pick_sew();
        return riscv_v_sew_t'(2'($unsigned($random(seed)) % 3));
    endfunction

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic issue(riscv_v_alu_ctrl_t c, riscv_v_alu_data_t a, riscv_v_alu_data_t b,
                         riscv_data_t s, riscv_v_mask_t m);
        expect_t e;
        in_valid = 1'b1;
        ctrl = c;
        srca = a;
        srcb = b;
        src_int = s;
        mask = m;
        e.vec = model_vec(c, a, b, s, m);
        e.int_r = model_int(c, a);
        e.mask_r = model_mask(c, a, b);
        e.due = cycle + 2;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_random(riscv_v_alu_op_t lo, riscv_v_alu_op_t hi);
        riscv_v_alu_ctrl_t c;
        c.op = pick_op(lo, hi);
        c.sew = pick_sew();
        c.is_signed = 1'($random(seed));
        c.is_negate_srca = 1'($random(seed));
        c.is_negate_result = 1'($random(seed));
        issue(c, rand_vec(), rand_vec(), $random(seed), 16'($random(seed)));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (exp_q.size() != 0 && waited < 20);
        #1;
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results never arrived", exp_q.size());
            error_count++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(string name, int errors_before);
        drain();
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        riscv_v_alu_ctrl_t c;
        riscv_v_alu_data_t a;
        riscv_v_alu_data_t b;
        int                start;
        int                pick;
        seed = 32'h403c59d5;
        rst_n = 1'b0;
        in_valid = 1'b0;
        ctrl = '0;
        srca = '0;
        srcb = '0;
        src_int = '0;
        mask = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start = error_count;
        repeat (60) run_random(op_and, op_sra);
        end_test("logic_shift", start);

        start = error_count;
        repeat (60) run_random(op_add, op_adc);
        end_test("add_sub_adc", start);

        start = error_count;
        repeat (80) begin
            c = '0;
            c.op = pick_op(op_seq, op_max);
            c.sew = pick_sew();
            c.is_signed = 1'($random(seed));
            a = corner_vec(c.sew);
            pick = int'($unsigned($random(seed)) % 3);
            b = (pick == 0) ? a : ((pick == 1) ? corner_vec(c.sew) : rand_vec());
            issue(c, a, b, '0, '0);
        end
        end_test("compare", start);

        start = error_count;
        for (int op = int'(op_mand); op <= int'(op_mxor); op++) begin
            for (int neg = 0; neg < 4; neg++) begin
                repeat (4) begin
                    c = '0;
                    c.op = riscv_v_alu_op_t'(5'(op));
                    c.sew = pick_sew();
                    c.is_negate_srca = neg[0];
                    c.is_negate_result = neg[1];
                    issue(c, rand_vec(), rand_vec(), $random(seed), 16'($random(seed)));
                end
            end
        end
        end_test("mask", start);

        start = error_count;
        repeat (40) run_random(op_i2v, op_v2i);
        end_test("permutation", start);

        start = error_count;
        repeat (60) begin
            if ($random(seed) & 1)
                run_random(op_and, op_v2i);
            else
                idle(1);
        end
        drain();
        repeat (3) run_random(op_add, op_max);
        rst_n = 1'b0;
        idle(1);
        // Only the last operation is still in flight when the reset lands
        if (exp_q.size() != 1) begin
            $display("Reset test expected one operation in flight, found %0d",
                     exp_q.size());
            error_count++;
        end
        exp_q.delete();
        idle(2);
        rst_n = 1'b1;
        idle(6);
        repeat (10) run_random(op_and, op_v2i);
        end_test("timing_reset", start);

        $display("Tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, error_count, dut0.checker0.fail_count);
        if (error_count == 0 && tests_failed == 0 && dut0.checker0.fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : riscv_v_exe_tb

// File: build.f
+incdir+test
verilog/riscv_v_pkg.sv
verilog/riscv_v_logic_alu.sv
verilog/riscv_v_arithmetic_alu.sv
verilog/riscv_v_mask_alu.sv
verilog/riscv_v_permutation_alu.sv
verilog/riscv_v_exe_alu.sv
verilog/riscv_v_exe_stage.sv
test/riscv_v_exe_checker.sv
test/riscv_v_exe_tb.sv

// File: Makefile
# Verilator build and run for the vector execute stage

SIMULATOR ?= verilator
TOP       ?= riscv_v_exe_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) test/riscv_v_exe_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIMULATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
